/* data/melee_wpn.dat */
// One 12-bit RGB word per line, row-major, 8 columns by 4 rows, 02F is transparent
02F
02F
02F
02F
02F
02F
02F
EEE
840
02F
CCC
CCC
CCC
CCC
EEE
FFF
840
A60
DDD
DDD
DDD
DDD
EEE
FFF
840
F00
02F
02F
02F
02F
02F
02F

/* data/archer_wpn.dat */
// One 12-bit RGB word per line, row-major, 6 columns by 6 rows, F00 is transparent
F00
F00
963
963
F00
F00
F00
963
F00
F00
02F
F00
963
F00
F00
F00
AAA
555
963
F00
F00
F00
AAA
555
F00
963
F00
F00
AAA
F00
F00
F00
963
963
F00
F00

/* build.f */
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/weapon_draw.sv
rtl/game_top.sv
sim/tb_game.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tb_game
result=$(./obj_dir/Vtb_game)
echo "$result"
echo "$result" | grep -qx "Done: no errors"

/* sim/tb_game.sv */
`timescale 1ns/1ps

module tb_game import game_pkg::*; ();

    localparam int H_ACTIVE    = 32;
    localparam int H_FP        = 2;
    localparam int H_SYNC      = 4;
    localparam int H_BP        = 2;
    localparam int V_ACTIVE    = 16;
    localparam int V_FP        = 1;
    localparam int V_SYNC      = 2;
    localparam int V_BP        = 1;
    localparam int H_TOTAL     = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL     = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int CLK_PERIOD  = 20;
    localparam int TEST_FRAMES = 10;  // Frames run by all tests together
    localparam int WATCHDOG_NS = (TEST_FRAMES + 2) * H_TOTAL * V_TOTAL * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst;
    logic [11:0] bg_rgb;
    game_state_t state;
    char_class_t char_class;
    logic        attack;
    logic [11:0] anim_x_offset;
    logic [11:0] melee_x;
    logic [11:0] melee_y;
    logic        melee_flip;
    logic [11:0] archer_x;
    logic [11:0] archer_y;
    logic        archer_flip;
    vga_bus_t    out_bus;

    logic [11:0] melee_img  [MELEE_W * MELEE_H];
    logic [11:0] archer_img [ARCHER_W * ARCHER_H];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          sprite_cnt;
    int          mdl_h;
    int          mdl_v;
    logic        prev_rst;
    logic [11:0] prev_bg;
    vga_bus_t    exp_q[$];
    vga_bus_t    raw_q[$];

    game_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[31:16]};
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(lcg_next() % 32'(hi - lo + 1));
    endfunction

    // Raw raster pixel for a counter position
    function automatic vga_bus_t timing_model(input int h, input int v, input logic [11:0] bg);
        vga_bus_t px;
        px.hcount = 11'(h);
        px.vcount = 11'(v);
        px.hblnk  = (h >= H_ACTIVE);
        px.vblnk  = (v >= V_ACTIVE);
        px.hsync  = (h >= H_ACTIVE + H_FP) && (h < H_ACTIVE + H_FP + H_SYNC);
        px.vsync  = (v >= V_ACTIVE + V_FP) && (v < V_ACTIVE + V_FP + V_SYNC);
        px.rgb    = (px.hblnk || px.vblnk) ? 12'h000 : bg;
        return px;
    endfunction

    function automatic vga_bus_t overlay_model(input vga_bus_t px);
        vga_bus_t    res;
        bit          is_melee;
        int          w;
        int          h;
        int          left;
        int          top;
        int          col;
        int          hx;
        int          vy;
        logic [11:0] word;
        res      = px;
        is_melee = (char_class == CLASS_MELEE);
        hx       = int'(px.hcount);
        vy       = int'(px.vcount);
        w        = is_melee ? MELEE_W : ARCHER_W;
        h        = is_melee ? MELEE_H : ARCHER_H;
        if (is_melee) begin
            left = melee_flip ? int'(melee_x) - int'(anim_x_offset)
                              : int'(melee_x) + int'(anim_x_offset);
            top  = int'(melee_y) - h;
        end else begin
            left = int'(archer_x);  // Bow ignores the swing offset
            top  = int'(archer_y) - h;
        end
        left = left - w / 2;
        col  = hx - left;
        if (is_melee ? melee_flip : archer_flip) col = w - 1 - col;
        if (attack && state == GAME_PLAY && (is_melee || char_class == CLASS_ARCHER) &&
            !px.hblnk && !px.vblnk && hx >= left && hx < left + w && vy >= top && vy < top + h) begin
            word = is_melee ? melee_img[(vy - top) * w + col] : archer_img[(vy - top) * w + col];
            if (word != (is_melee ? MELEE_KEY : ARCHER_KEY)) begin
                res.rgb = word;
            end
        end
        return res;
    endfunction

    task automatic report_field(input string name, input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp) $display("FAILED %s got %h expected %h", name, got, exp);
    endtask

    task automatic compare_bus(input string name, input vga_bus_t got, input vga_bus_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            report_field({name, ".hcount"}, {1'b0, got.hcount}, {1'b0, exp.hcount});
            report_field({name, ".vcount"}, {1'b0, got.vcount}, {1'b0, exp.vcount});
            report_field({name, ".hsync"}, 12'(got.hsync), 12'(exp.hsync));
            report_field({name, ".vsync"}, 12'(got.vsync), 12'(exp.vsync));
            report_field({name, ".hblnk"}, 12'(got.hblnk), 12'(exp.hblnk));
            report_field({name, ".vblnk"}, 12'(got.vblnk), 12'(exp.vblnk));
            report_field({name, ".rgb"}, got.rgb, exp.rgb);
        end
    endtask

    task automatic compare_rgb(input string name, input logic [11:0] got, input logic [11:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // Reference raster and overlay compared PIPE_DEPTH clocks later
    always @(negedge clk) begin
        vga_bus_t raw;
        vga_bus_t exp_now;
        vga_bus_t plain;
        if (prev_rst) begin
            raw   = '0;
            mdl_h = 0;
            mdl_v = 0;
        end else begin
            raw   = timing_model(mdl_h, mdl_v, prev_bg);
            mdl_h = (mdl_h + 1) % H_TOTAL;
            if (mdl_h == 0) mdl_v = (mdl_v + 1) % V_TOTAL;
        end
        exp_now = overlay_model(raw);
        if (rst) begin
            raw     = '0;
            exp_now = '0;
        end
        exp_q.push_back(exp_now);
        raw_q.push_back(raw);
        compare_bus("out_bus", out_bus, exp_q.pop_front());
        plain = raw_q.pop_front();
        if (out_bus.rgb !== plain.rgb) sprite_cnt++;  // Pixel replaced by the DUT
        if (out_bus.hblnk || out_bus.vblnk) compare_rgb("out_bus.rgb", out_bus.rgb, 12'h000);
        prev_rst = rst;
        prev_bg  = bg_rgb;
    end

    // Returns when out_bus comes back to the frame origin
    task automatic run_frame();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (n < 2 || out_bus.hcount != 11'd0 || out_bus.vcount != 11'd0);
    endtask

    // Lets pixels of the previous setup leave the pipeline
    task automatic restart_count();
        repeat (PIPE_DEPTH) @(posedge clk);
        sprite_cnt = 0;
    endtask

    task automatic expect_sprites(input string what, input bit want);
        @(posedge clk);
        if ((sprite_cnt > 0) != want) begin
            errors++;
            $display("%s drew %0d sprite pixels in a frame, %s expected", what, sprite_cnt,
                     want ? "some were" : "none were");
        end
    endtask

    task automatic test_reset();
        int i;
        for (i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) rst <= 1'b0;
            @(negedge clk);
            compare_bus("out_bus during reset", out_bus, '0);
        end
        repeat (PIPE_DEPTH) begin
            @(negedge clk);
            compare_bus("out_bus after reset", out_bus, '0);
        end
        run_frame();
    endtask

    task automatic test_melee(input logic flip);
        @(posedge clk);
        state         <= GAME_PLAY;
        char_class    <= CLASS_MELEE;
        attack        <= 1'b1;
        melee_flip    <= flip;
        melee_x       <= 12'(rand_range(8, 24));
        melee_y       <= 12'(rand_range(MELEE_H, V_ACTIVE));
        anim_x_offset <= 12'(rand_range(1, 3));
        bg_rgb        <= 12'(lcg_next());
        restart_count();
        run_frame();
        expect_sprites(flip ? "Mirrored melee" : "Melee", 1'b1);
    endtask

    task automatic test_archer();
        int f;
        for (f = 0; f < 2; f++) begin
            @(posedge clk);
            char_class    <= CLASS_ARCHER;
            archer_flip   <= f[0];
            archer_x      <= 12'(rand_range(ARCHER_W / 2, H_ACTIVE - ARCHER_W / 2));
            archer_y      <= 12'(rand_range(ARCHER_H, V_ACTIVE));
            anim_x_offset <= 12'(rand_range(1, 7));
            restart_count();
            run_frame();
            expect_sprites("Archer", 1'b1);
        end
    endtask

    // Attack low, idle, game over, then no class
    task automatic test_disabled();
        int i;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            attack     <= (i != 0);
            state      <= game_state_t'((i == 1) ? GAME_IDLE : (i == 2) ? GAME_OVER : GAME_PLAY);
            char_class <= char_class_t'((i == 3) ? CLASS_NONE : CLASS_MELEE);
            melee_x    <= 12'(rand_range(8, 24));
            melee_y    <= 12'(rand_range(MELEE_H, V_ACTIVE));
            restart_count();
            run_frame();
            expect_sprites("Disabled overlay", 1'b0);
        end
    endtask

    task automatic test_blanking();
        @(posedge clk);
        state         <= GAME_PLAY;
        char_class    <= CLASS_MELEE;
        attack        <= 1'b1;
        melee_flip    <= 1'b0;
        melee_x       <= 12'(H_ACTIVE - 2);  // Box spans columns 26 to 33
        melee_y       <= 12'(V_ACTIVE / 2);
        anim_x_offset <= '0;
        restart_count();
        run_frame();
        expect_sprites("Sprite at the right edge", 1'b1);
    endtask

    initial begin
        lcg_state     = 32'd57570;
        rst           = 1'b1;
        bg_rgb        = 12'(lcg_next());
        state         = GAME_IDLE;
        char_class    = CLASS_NONE;
        attack        = 1'b0;
        anim_x_offset = '0;
        melee_x       = '0;
        melee_y       = '0;
        melee_flip    = 1'b0;
        archer_x      = '0;
        archer_y      = '0;
        archer_flip   = 1'b0;
        errors        = 0;
        checks        = 0;
        sprite_cnt    = 0;
        prev_rst      = 1'b1;
        prev_bg       = '0;
        repeat (PIPE_DEPTH) begin
            exp_q.push_back('0);
            raw_q.push_back('0);
        end
        $readmemh("data/melee_wpn.dat", melee_img);
        $readmemh("data/archer_wpn.dat", archer_img);
        test_reset();
        test_melee(1'b0);
        test_melee(1'b1);
        test_archer();
        test_disabled();
        test_blanking();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* rtl/game_top.sv */
`timescale 1ns/1ps

module game_top import game_pkg::*; #(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_FP     = DEF_H_FP,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BP     = DEF_H_BP,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_FP     = DEF_V_FP,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BP     = DEF_V_BP
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] bg_rgb,
    input  game_state_t state,
    input  char_class_t char_class,
    input  logic        attack,
    input  logic [11:0] anim_x_offset,
    input  logic [11:0] melee_x,
    input  logic [11:0] melee_y,
    input  logic        melee_flip,
    input  logic [11:0] archer_x,
    input  logic [11:0] archer_y,
    input  logic        archer_flip,
    output vga_bus_t    out_bus
);

    vga_bus_t raw_bus;  // Timing output before the overlay

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) u_timing (
        .clk    (clk),
        .rst    (rst),
        .bg_rgb (bg_rgb),
        .bus    (raw_bus)
    );

    weapon_draw u_weapon (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .char_class    (char_class),
        .attack        (attack),
        .anim_x_offset (anim_x_offset),
        .melee_x       (melee_x),
        .melee_y       (melee_y),
        .melee_flip    (melee_flip),
        .archer_x      (archer_x),
        .archer_y      (archer_y),
        .archer_flip   (archer_flip),
        .in_bus        (raw_bus),
        .out_bus       (out_bus)
    );

endmodule

/* rtl/weapon_draw.sv */
`timescale 1ns/1ps

module weapon_draw import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  char_class_t char_class,
    input  logic        attack,
    input  logic [11:0] anim_x_offset,
    input  logic [11:0] melee_x,
    input  logic [11:0] melee_y,
    input  logic        melee_flip,
    input  logic [11:0] archer_x,
    input  logic [11:0] archer_y,
    input  logic        archer_flip,
    input  vga_bus_t    in_bus,
    output vga_bus_t    out_bus
);

    localparam int MELEE_DEPTH  = MELEE_W * MELEE_H;
    localparam int ARCHER_DEPTH = ARCHER_W * ARCHER_H;
    localparam int ADDR_W       = $clog2(ARCHER_DEPTH);
    localparam int M_ADDR_W     = $clog2(MELEE_DEPTH);

    logic [11:0] melee_rom  [MELEE_DEPTH];
    logic [11:0] archer_rom [ARCHER_DEPTH];

    initial $readmemh("data/melee_wpn.dat", melee_rom);
    initial $readmemh("data/archer_wpn.dat", archer_rom);

    logic              draw_en;
    logic [11:0]       m_cx;
    logic [11:0]       m_rel_x;
    logic [11:0]       m_rel_y;
    logic [11:0]       m_col;
    logic [11:0]       a_rel_x;
    logic [11:0]       a_rel_y;
    logic [11:0]       a_col;
    logic              hit_nxt;
    logic              melee_nxt;
    logic [ADDR_W-1:0] addr_nxt;

    vga_bus_t          s1_bus;
    logic              s1_hit;
    logic              s1_melee;
    logic [ADDR_W-1:0] s1_addr;

    vga_bus_t          s2_bus;
    logic              s2_hit;
    logic              s2_melee;
    logic [11:0]       s2_pix;

    always_comb begin
        draw_en = attack && (state == GAME_PLAY) && !in_bus.hblnk && !in_bus.vblnk;

        // Melee box follows the swing offset, mirrored side when flipped
        m_cx    = melee_flip ? melee_x - anim_x_offset : melee_x + anim_x_offset;
        m_rel_x = {1'b0, in_bus.hcount} - (m_cx - 12'(MELEE_W / 2));
        m_rel_y = {1'b0, in_bus.vcount} - (melee_y - 12'(MELEE_H));
        m_col   = melee_flip ? 12'(MELEE_W - 1) - m_rel_x : m_rel_x;

        a_rel_x = {1'b0, in_bus.hcount} - (archer_x - 12'(ARCHER_W / 2));
        a_rel_y = {1'b0, in_bus.vcount} - (archer_y - 12'(ARCHER_H));
        a_col   = archer_flip ? 12'(ARCHER_W - 1) - a_rel_x : a_rel_x;

        hit_nxt   = 1'b0;
        melee_nxt = 1'b0;
        addr_nxt  = '0;
        case (char_class)
            CLASS_MELEE: begin
                melee_nxt = 1'b1;
                hit_nxt   = draw_en && (m_rel_x < MELEE_W) && (m_rel_y < MELEE_H);
                addr_nxt  = ADDR_W'(m_rel_y * MELEE_W + m_col);
            end
            CLASS_ARCHER: begin
                hit_nxt  = draw_en && (a_rel_x < ARCHER_W) && (a_rel_y < ARCHER_H);
                addr_nxt = ADDR_W'(a_rel_y * ARCHER_W + a_col);
            end
            default: begin
                hit_nxt = 1'b0;  // No weapon for this class
            end
        endcase
    end

    // Stage 1: hit test and ROM address
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_bus   <= '0;
            s1_hit   <= 1'b0;
            s1_melee <= 1'b0;
        end else begin
            s1_bus   <= in_bus;
            s1_hit   <= hit_nxt;
            s1_melee <= melee_nxt;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= addr_nxt;
    end

    // Stage 2: ROM read
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_bus   <= '0;
            s2_hit   <= 1'b0;
            s2_melee <= 1'b0;
        end else begin
            s2_bus   <= s1_bus;
            s2_hit   <= s1_hit;
            s2_melee <= s1_melee;
        end
    end

    always_ff @(posedge clk) begin
        s2_pix <= s1_melee ? melee_rom[s1_addr[M_ADDR_W-1:0]] : archer_rom[s1_addr];
    end

    // Stage 3: colour key and overlay
    always_ff @(posedge clk) begin
        if (rst) begin
            out_bus <= '0;
        end else begin
            out_bus <= s2_bus;
            if (s2_hit && (s2_pix != (s2_melee ? MELEE_KEY : ARCHER_KEY))) begin
                out_bus.rgb <= s2_pix;
            end
        end
    end

endmodule

/* rtl/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing import game_pkg::*; #(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_FP     = DEF_H_FP,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BP     = DEF_H_BP,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_FP     = DEF_V_FP,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BP     = DEF_V_BP
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] bg_rgb,
    output vga_bus_t    bus
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

    logic [10:0] hcnt;
    logic [10:0] vcnt;
    logic        hblnk_nxt;
    logic        vblnk_nxt;
    logic        hsync_nxt;
    logic        vsync_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == H_TOTAL - 1) begin
            hcnt <= '0;
            vcnt <= (vcnt == V_TOTAL - 1) ? '0 : vcnt + 11'd1;  // Line wrap steps the frame
        end else begin
            hcnt <= hcnt + 11'd1;
        end
    end

    always_comb begin
        hblnk_nxt = (hcnt >= H_ACTIVE);
        vblnk_nxt = (vcnt >= V_ACTIVE);
        hsync_nxt = (hcnt >= H_ACTIVE + H_FP) && (hcnt < H_ACTIVE + H_FP + H_SYNC);
        vsync_nxt = (vcnt >= V_ACTIVE + V_FP) && (vcnt < V_ACTIVE + V_FP + V_SYNC);
    end

    // Counter value and its decode land in the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            bus <= '0;
        end else begin
            bus.hcount <= hcnt;
            bus.vcount <= vcnt;
            bus.hsync  <= hsync_nxt;
            bus.vsync  <= vsync_nxt;
            bus.hblnk  <= hblnk_nxt;
            bus.vblnk  <= vblnk_nxt;
            bus.rgb    <= (hblnk_nxt || vblnk_nxt) ? 12'h000 : bg_rgb;  // Black in blanking
        end
    end

endmodule

/* rtl/game_pkg.sv */
package game_pkg;

    // Raster pixel bus, one pixel per clock
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_bus_t;

    typedef enum logic [1:0] {
        GAME_IDLE,
        GAME_PLAY,
        GAME_OVER
    } game_state_t;

    typedef enum logic [1:0] {
        CLASS_NONE,
        CLASS_MELEE,
        CLASS_ARCHER
    } char_class_t;

    localparam logic [11:0] MELEE_KEY  = 12'h02F;  // Transparent colours
    localparam logic [11:0] ARCHER_KEY = 12'hF00;

    localparam int MELEE_W  = 8;
    localparam int MELEE_H  = 4;
    localparam int ARCHER_W = 6;
    localparam int ARCHER_H = 6;

    // 800x600 raster
    localparam int DEF_H_ACTIVE = 800;
    localparam int DEF_H_FP     = 40;
    localparam int DEF_H_SYNC   = 128;
    localparam int DEF_H_BP     = 88;
    localparam int DEF_V_ACTIVE = 600;
    localparam int DEF_V_FP     = 1;
    localparam int DEF_V_SYNC   = 4;
    localparam int DEF_V_BP     = 23;

    localparam int PIPE_DEPTH = 3;  // Overlay latency in clocks

endpackage
